// ==== core_chk.sv ====
`timescale 1ns/1ps

module core_chk (
    input logic               clk,
    input logic               reset_i,
    input logic               ok1_i,
    input logic               full_i,
    input logic               m_wen_i,
    input cpu_pkg::reg_addr_t m_wnum_i,
    input cpu_pkg::word_t     m_wdata_i,
    input cpu_pkg::word_t     m_pc_i,
    input logic               s_wen_i,
    input cpu_pkg::reg_addr_t s_wnum_i,
    input cpu_pkg::word_t     s_wdata_i,
    input cpu_pkg::word_t     s_pc_i,
    input cpu_pkg::reg_addr_t exp_m_wnum_i,
    input cpu_pkg::word_t     exp_m_wdata_i,
    input cpu_pkg::word_t     exp_m_pc_i,
    input cpu_pkg::reg_addr_t exp_s_wnum_i,
    input cpu_pkg::word_t     exp_s_wdata_i,
    input cpu_pkg::word_t     exp_s_pc_i
);
    int unsigned fail_cnt = 0;

    // expected values move on the falling edge, so both sides are settled here
    a_master_wb: assert property (@(posedge clk) disable iff (reset_i)
        m_wen_i |-> m_wnum_i == exp_m_wnum_i && m_wdata_i == exp_m_wdata_i
            && m_pc_i == exp_m_pc_i) else begin
        fail_cnt++;
        $error("MISMATCH t=%0t wb_master wnum exp=%0d got=%0d wdata exp=%h got=%h pc exp=%h got=%h",
            $time, exp_m_wnum_i, $sampled(m_wnum_i), exp_m_wdata_i, $sampled(m_wdata_i),
            exp_m_pc_i, $sampled(m_pc_i));
    end

    a_slave_wb: assert property (@(posedge clk) disable iff (reset_i)
        s_wen_i |-> s_wnum_i == exp_s_wnum_i && s_wdata_i == exp_s_wdata_i
            && s_pc_i == exp_s_pc_i) else begin
        fail_cnt++;
        $error("MISMATCH t=%0t wb_slave wnum exp=%0d got=%0d wdata exp=%h got=%h pc exp=%h got=%h",
            $time, exp_s_wnum_i, $sampled(s_wnum_i), exp_s_wdata_i, $sampled(s_wdata_i),
            exp_s_pc_i, $sampled(s_pc_i));
    end

    // a same-cycle pair is two neighbouring words
    a_pair_pc: assert property (@(posedge clk) disable iff (reset_i)
        m_wen_i && s_wen_i |-> s_pc_i == m_pc_i + 32'd4) else begin
        fail_cnt++;
        $error("MISMATCH t=%0t wb_slave_pc_o exp=%h got=%h",
            $time, $sampled(m_pc_i) + 32'd4, $sampled(s_pc_i));
    end

    a_no_strobe_full: assert property (@(posedge clk) disable iff (reset_i)
        !(full_i && ok1_i)) else begin
        fail_cnt++;
        $error("fetch strobe was sent while fifo_full_o was high");
    end

    a_wen_reset: assert property (@(posedge clk) reset_i |=> !m_wen_i && !s_wen_i) else begin
        fail_cnt++;
        $error("a writeback enable was high during reset or in the cycle after it");
    end

endmodule

// ==== core_ifs.sv ====
`timescale 1ns/1ps

// two oldest queue entries and the pop strobes
interface issue_if #(
    parameter int CNT_W = 4
);
    import cpu_pkg::*;

    word_t            master_inst;
    word_t            master_pc;
    word_t            slave_inst;
    word_t            slave_pc;
    logic [CNT_W-1:0] count;
    logic             pop_master;
    logic             pop_slave;

    modport source (
        output master_inst, master_pc, slave_inst, slave_pc, count,
        input  pop_master, pop_slave
    );
    modport sink (
        input  master_inst, master_pc, slave_inst, slave_pc, count,
        output pop_master, pop_slave
    );
endinterface

// lane 0 is master, lane 1 is slave
interface exec_if;
    import cpu_pkg::*;

    logic [1:0] valid;
    alu_op_e    alu_op [2];
    word_t      src_a [2];
    word_t      src_b [2];
    logic [1:0] wen;
    reg_addr_t  waddr [2];
    word_t      pc [2];

    modport source (output valid, alu_op, src_a, src_b, wen, waddr, pc);
    modport sink   (input  valid, alu_op, src_a, src_b, wen, waddr, pc);
endinterface

interface bypass_if;
    import cpu_pkg::*;

    logic [1:0] wen;
    reg_addr_t  waddr [2];
    word_t      result [2];

    modport source (output wen, waddr, result);
    modport sink   (input  wen, waddr, result);
endinterface

interface wb_if;
    import cpu_pkg::*;

    logic [1:0] wen;
    reg_addr_t  waddr [2];
    word_t      wdata [2];
    word_t      pc [2];

    modport source (output wen, waddr, wdata, pc);
    modport sink   (input  wen, waddr, wdata, pc);
endinterface

// ==== cpu_pkg.sv ====
package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    typedef enum logic [3:0] {
        NOP,
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLT,
        SLL,
        LUI
    } alu_op_e;

    // primary opcodes
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_LUI     = 6'h0f;

    // funct field of SPECIAL
    localparam logic [5:0] FN_SLL     = 6'h00;
    localparam logic [5:0] FN_ADDU    = 6'h21;
    localparam logic [5:0] FN_SUBU    = 6'h23;
    localparam logic [5:0] FN_AND     = 6'h24;
    localparam logic [5:0] FN_OR      = 6'h25;
    localparam logic [5:0] FN_XOR     = 6'h26;
    localparam logic [5:0] FN_SLT     = 6'h2a;

    localparam word_t RESET_PC = 32'hbfc00000;

endpackage

// ==== decoder.sv ====
`timescale 1ns/1ps

module decoder (
    input  cpu_pkg::word_t     inst_i,
    output cpu_pkg::alu_op_e   alu_op_o,
    output cpu_pkg::reg_addr_t rs_o,
    output cpu_pkg::reg_addr_t rt_o,
    output cpu_pkg::reg_addr_t waddr_o,
    output logic               reads_rt_o,
    output logic               use_imm_o,
    output logic               use_shamt_o,
    output cpu_pkg::word_t     imm_o,
    output logic               wen_o
);
    import cpu_pkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    logic       known;

    assign opcode = inst_i[31:26];
    assign funct  = inst_i[5:0];
    assign rs_o   = inst_i[25:21];
    assign rt_o   = inst_i[20:16];

    always_comb begin
        alu_op_o    = NOP;
        waddr_o     = inst_i[15:11];
        reads_rt_o  = 1'b0;
        use_imm_o   = 1'b0;
        use_shamt_o = 1'b0;
        imm_o       = {{16{inst_i[15]}}, inst_i[15:0]};
        known       = 1'b1;
        case (opcode)
            OP_SPECIAL: begin
                reads_rt_o = 1'b1;
                case (funct)
                    FN_ADDU: alu_op_o = ADD;
                    FN_SUBU: alu_op_o = SUB;
                    FN_AND:  alu_op_o = AND;
                    FN_OR:   alu_op_o = OR;
                    FN_XOR:  alu_op_o = XOR;
                    FN_SLT:  alu_op_o = SLT;
                    FN_SLL: begin
                        alu_op_o    = SLL;
                        use_shamt_o = 1'b1;
                    end
                    default: known = 1'b0;
                endcase
            end
            OP_ADDIU: begin
                alu_op_o  = ADD;
                waddr_o   = rt_o;
                use_imm_o = 1'b1;
            end
            OP_ORI: begin
                alu_op_o  = OR;
                waddr_o   = rt_o;
                use_imm_o = 1'b1;
                imm_o     = {16'h0000, inst_i[15:0]};
            end
            OP_LUI: begin
                alu_op_o  = LUI;
                waddr_o   = rt_o;
                use_imm_o = 1'b1;
                imm_o     = {inst_i[15:0], 16'h0000};
            end
            default: known = 1'b0;
        endcase
    end

    // unknown words and r0 targets retire as no-ops
    assign wen_o = known && (waddr_o != '0);

endmodule

// ==== dual_issue_core.sv ====
`timescale 1ns/1ps

module dual_issue_core #(
    parameter int             FIFO_DEPTH = 8,
    parameter cpu_pkg::word_t START_PC   = cpu_pkg::RESET_PC
) (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               inst_data_ok1_i,
    input  logic               inst_data_ok2_i,
    input  cpu_pkg::word_t     inst_rdata1_i,
    input  cpu_pkg::word_t     inst_rdata2_i,
    output logic               fifo_full_o,
    output logic               wb_master_wen_o,
    output cpu_pkg::reg_addr_t wb_master_wnum_o,
    output cpu_pkg::word_t     wb_master_wdata_o,
    output cpu_pkg::word_t     wb_master_pc_o,
    output logic               wb_slave_wen_o,
    output cpu_pkg::reg_addr_t wb_slave_wnum_o,
    output cpu_pkg::word_t     wb_slave_wdata_o,
    output cpu_pkg::word_t     wb_slave_pc_o
);
    import cpu_pkg::*;

    reg_addr_t rf_raddr [4];
    word_t     rf_rdata [4];

    issue_if #(.CNT_W($clog2(FIFO_DEPTH) + 1)) iss_bus ();
    exec_if   ex_bus ();
    bypass_if byp_bus ();
    wb_if     wb_bus ();

    inst_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .START_PC   (START_PC)
    ) u_inst_fifo (
        .clk        (clk),
        .reset_i    (reset_i),
        .data_ok1_i (inst_data_ok1_i),
        .data_ok2_i (inst_data_ok2_i),
        .rdata1_i   (inst_rdata1_i),
        .rdata2_i   (inst_rdata2_i),
        .full_o     (fifo_full_o),
        .iss        (iss_bus)
    );

    issue_stage u_issue_stage (
        .iss         (iss_bus),
        .ex          (ex_bus),
        .byp         (byp_bus),
        .rf_raddr0_o (rf_raddr[0]),
        .rf_raddr1_o (rf_raddr[1]),
        .rf_raddr2_o (rf_raddr[2]),
        .rf_raddr3_o (rf_raddr[3]),
        .rf_rdata0_i (rf_rdata[0]),
        .rf_rdata1_i (rf_rdata[1]),
        .rf_rdata2_i (rf_rdata[2]),
        .rf_rdata3_i (rf_rdata[3])
    );

    regfile u_regfile (
        .clk      (clk),
        .raddr0_i (rf_raddr[0]),
        .raddr1_i (rf_raddr[1]),
        .raddr2_i (rf_raddr[2]),
        .raddr3_i (rf_raddr[3]),
        .rdata0_o (rf_rdata[0]),
        .rdata1_o (rf_rdata[1]),
        .rdata2_o (rf_rdata[2]),
        .rdata3_o (rf_rdata[3]),
        .wb       (wb_bus)
    );

    execute_stage u_execute_stage (
        .clk     (clk),
        .reset_i (reset_i),
        .ex      (ex_bus),
        .byp     (byp_bus),
        .wb      (wb_bus)
    );

    assign wb_master_wen_o   = wb_bus.wen[0];
    assign wb_master_wnum_o  = wb_bus.waddr[0];
    assign wb_master_wdata_o = wb_bus.wdata[0];
    assign wb_master_pc_o    = wb_bus.pc[0];
    assign wb_slave_wen_o    = wb_bus.wen[1];
    assign wb_slave_wnum_o   = wb_bus.waddr[1];
    assign wb_slave_wdata_o  = wb_bus.wdata[1];
    assign wb_slave_pc_o     = wb_bus.pc[1];

endmodule

// ==== execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
    input  logic     clk,
    input  logic     reset_i,
    exec_if.sink     ex,
    bypass_if.source byp,
    wb_if.source     wb
);
    import cpu_pkg::*;

    logic [1:0] e_valid;
    logic [1:0] e_wen;
    alu_op_e    e_op [2];
    word_t      e_a [2];
    word_t      e_b [2];
    reg_addr_t  e_waddr [2];
    word_t      e_pc [2];
    word_t      e_res [2];

    function automatic word_t alu(alu_op_e op, word_t a, word_t b);
        case (op)
            ADD:     return a + b;
            SUB:     return a - b;
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            SLT:     return {31'd0, $signed(a) < $signed(b)};
            SLL:     return b << a[4:0];
            LUI:     return b;
            default: return '0;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (reset_i) begin
            e_valid <= '0;
            wb.wen  <= '0;
        end else begin
            e_valid <= ex.valid;
            wb.wen  <= byp.wen;
        end
    end

    always_ff @(posedge clk) begin
        e_wen <= ex.wen;
        for (int l = 0; l < 2; l++) begin
            e_op[l]     <= ex.alu_op[l];
            e_a[l]      <= ex.src_a[l];
            e_b[l]      <= ex.src_b[l];
            e_waddr[l]  <= ex.waddr[l];
            e_pc[l]     <= ex.pc[l];
            wb.waddr[l] <= e_waddr[l];
            wb.wdata[l] <= e_res[l];
            wb.pc[l]    <= e_pc[l];
        end
    end

    // bubbles never write
    assign byp.wen = e_valid & e_wen;

    for (genvar l = 0; l < 2; l++) begin : g_alu
        assign e_res[l]      = alu(e_op[l], e_a[l], e_b[l]);
        assign byp.waddr[l]  = e_waddr[l];
        assign byp.result[l] = e_res[l];
    end

endmodule

// ==== files.f ====
cpu_pkg.sv
core_ifs.sv
inst_fifo.sv
decoder.sv
issue_stage.sv
regfile.sv
execute_stage.sv
dual_issue_core.sv
tb_clock.sv
core_chk.sv
tb_dual_issue.sv

// ==== inst_fifo.sv ====
`timescale 1ns/1ps

module inst_fifo #(
    parameter int             FIFO_DEPTH = 8,
    parameter cpu_pkg::word_t START_PC   = cpu_pkg::RESET_PC
) (
    input  logic           clk,
    input  logic           reset_i,
    input  logic           data_ok1_i,
    input  logic           data_ok2_i,
    input  cpu_pkg::word_t rdata1_i,
    input  cpu_pkg::word_t rdata2_i,
    output logic           full_o,
    issue_if.source        iss
);
    import cpu_pkg::*;

    localparam int AW = $clog2(FIFO_DEPTH);

    word_t         inst_mem [FIFO_DEPTH];
    word_t         pc_mem [FIFO_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW-1:0] wr_ptr_nxt;
    logic [AW-1:0] rd_ptr_nxt;
    logic [AW:0]   count;
    logic [AW:0]   n_wr;
    logic [AW:0]   n_rd;
    word_t         pc_q;
    logic          accept;

    // strobes are dropped while fewer than two entries are free
    assign accept     = data_ok1_i && !full_o;
    assign n_wr       = {{(AW - 1){1'b0}}, accept && data_ok2_i, accept && !data_ok2_i};
    assign n_rd       = {{(AW - 1){1'b0}}, iss.pop_slave, iss.pop_master && !iss.pop_slave};
    assign wr_ptr_nxt = wr_ptr + 1'b1;
    assign rd_ptr_nxt = rd_ptr + 1'b1;
    assign full_o     = count > (AW + 1)'(FIFO_DEPTH - 2);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            pc_q   <= START_PC;
        end else begin
            wr_ptr <= wr_ptr + n_wr[AW-1:0];
            rd_ptr <= rd_ptr + n_rd[AW-1:0];
            count  <= count + n_wr - n_rd;
            if (accept) begin
                pc_q <= pc_q + (data_ok2_i ? 32'd8 : 32'd4);
            end
        end
    end

    // second word is the one after the first in program order
    always_ff @(posedge clk) begin
        if (accept) begin
            inst_mem[wr_ptr] <= rdata1_i;
            pc_mem[wr_ptr]   <= pc_q;
            if (data_ok2_i) begin
                inst_mem[wr_ptr_nxt] <= rdata2_i;
                pc_mem[wr_ptr_nxt]   <= pc_q + 32'd4;
            end
        end
    end

    assign iss.master_inst = inst_mem[rd_ptr];
    assign iss.master_pc   = pc_mem[rd_ptr];
    assign iss.slave_inst  = inst_mem[rd_ptr_nxt];
    assign iss.slave_pc    = pc_mem[rd_ptr_nxt];
    assign iss.count       = count;

endmodule

// ==== issue_stage.sv ====
`timescale 1ns/1ps

module issue_stage (
    issue_if.sink              iss,
    exec_if.source             ex,
    bypass_if.sink             byp,
    output cpu_pkg::reg_addr_t rf_raddr0_o,
    output cpu_pkg::reg_addr_t rf_raddr1_o,
    output cpu_pkg::reg_addr_t rf_raddr2_o,
    output cpu_pkg::reg_addr_t rf_raddr3_o,
    input  cpu_pkg::word_t     rf_rdata0_i,
    input  cpu_pkg::word_t     rf_rdata1_i,
    input  cpu_pkg::word_t     rf_rdata2_i,
    input  cpu_pkg::word_t     rf_rdata3_i
);
    import cpu_pkg::*;

    word_t      inst [2];
    word_t      pc [2];
    alu_op_e    d_op [2];
    reg_addr_t  d_rs [2];
    reg_addr_t  d_rt [2];
    reg_addr_t  d_waddr [2];
    word_t      d_imm [2];
    logic [1:0] d_reads_rt;
    logic [1:0] d_use_imm;
    logic [1:0] d_use_shamt;
    logic [1:0] d_wen;
    word_t      op_rf [4];
    word_t      op_val [4];
    logic       slave_dep;
    logic       issue_m;
    logic       issue_s;

    assign inst[0] = iss.master_inst;
    assign inst[1] = iss.slave_inst;
    assign pc[0]   = iss.master_pc;
    assign pc[1]   = iss.slave_pc;

    // operand order is master rs, master rt, slave rs, slave rt
    assign rf_raddr0_o = d_rs[0];
    assign rf_raddr1_o = d_rt[0];
    assign rf_raddr2_o = d_rs[1];
    assign rf_raddr3_o = d_rt[1];
    assign op_rf[0]    = rf_rdata0_i;
    assign op_rf[1]    = rf_rdata1_i;
    assign op_rf[2]    = rf_rdata2_i;
    assign op_rf[3]    = rf_rdata3_i;

    // execute results override the register file, slave is younger
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            op_val[i] = op_rf[i];
            if (byp.wen[0] && byp.waddr[0] == (i[0] ? d_rt[i / 2] : d_rs[i / 2])) begin
                op_val[i] = byp.result[0];
            end
            if (byp.wen[1] && byp.waddr[1] == (i[0] ? d_rt[i / 2] : d_rs[i / 2])) begin
                op_val[i] = byp.result[1];
            end
        end
    end

    // rs counts as read for every slave word
    assign slave_dep = d_wen[0] && ((d_rs[1] == d_waddr[0]) ||
                                    (d_reads_rt[1] && d_rt[1] == d_waddr[0]));
    assign issue_m   = iss.count != '0;
    assign issue_s   = issue_m && (iss.count >= 2) && !slave_dep;

    assign iss.pop_master = issue_m;
    assign iss.pop_slave  = issue_s;
    assign ex.valid       = {issue_s, issue_m};
    assign ex.wen         = d_wen;

    for (genvar l = 0; l < 2; l++) begin : g_lane
        decoder u_decoder (
            .inst_i      (inst[l]),
            .alu_op_o    (d_op[l]),
            .rs_o        (d_rs[l]),
            .rt_o        (d_rt[l]),
            .waddr_o     (d_waddr[l]),
            .reads_rt_o  (d_reads_rt[l]),
            .use_imm_o   (d_use_imm[l]),
            .use_shamt_o (d_use_shamt[l]),
            .imm_o       (d_imm[l]),
            .wen_o       (d_wen[l])
        );

        assign ex.alu_op[l] = d_op[l];
        assign ex.src_a[l]  = d_use_shamt[l] ? {27'd0, inst[l][10:6]} : op_val[2 * l];
        assign ex.src_b[l]  = d_use_imm[l] ? d_imm[l] : op_val[2 * l + 1];
        assign ex.waddr[l]  = d_waddr[l];
        assign ex.pc[l]     = pc[l];
    end

endmodule

// ==== regfile.sv ====
`timescale 1ns/1ps

module regfile (
    input  logic               clk,
    input  cpu_pkg::reg_addr_t raddr0_i,
    input  cpu_pkg::reg_addr_t raddr1_i,
    input  cpu_pkg::reg_addr_t raddr2_i,
    input  cpu_pkg::reg_addr_t raddr3_i,
    output cpu_pkg::word_t     rdata0_o,
    output cpu_pkg::word_t     rdata1_o,
    output cpu_pkg::word_t     rdata2_o,
    output cpu_pkg::word_t     rdata3_o,
    wb_if.sink                 wb
);
    import cpu_pkg::*;

    word_t regs [32];

    // slave write lands last and wins
    always_ff @(posedge clk) begin
        if (wb.wen[0]) begin
            regs[wb.waddr[0]] <= wb.wdata[0];
        end
        if (wb.wen[1]) begin
            regs[wb.waddr[1]] <= wb.wdata[1];
        end
    end

    function automatic word_t read_port(reg_addr_t addr);
        word_t val;
        val = regs[addr];
        if (wb.wen[0] && wb.waddr[0] == addr) begin
            val = wb.wdata[0];
        end
        if (wb.wen[1] && wb.waddr[1] == addr) begin
            val = wb.wdata[1];
        end
        if (addr == '0) begin
            val = '0;
        end
        return val;
    endfunction

    always_comb begin
        rdata0_o = read_port(raddr0_i);
        rdata1_o = read_port(raddr1_i);
        rdata2_o = read_port(raddr2_i);
        rdata3_o = read_port(raddr3_i);
    end

endmodule

// ==== tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS = 8
) (
    output logic clk_o
);
    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0) clk_o = ~clk_o;
        end
    end

endmodule

// ==== tb_dual_issue.sv ====
`timescale 1ns/1ps

module tb_dual_issue;
    import cpu_pkg::*;

    localparam int          CLK_PERIOD      = 8;
    localparam int          RESET_CYCLES    = 3;
    localparam int          DRIVE_DELAY     = 1;
    localparam int unsigned SEED            = 32'h9e53;
    localparam word_t       START_PC        = 32'hbfc00000;
    localparam int          N_SINGLE        = 40;
    localparam int          N_PAIR          = 20;
    localparam int          N_CHAIN         = 30;
    localparam int          N_BURST         = 32;
    localparam int          DRAIN_LIMIT     = 64;
    // preload is 14 words, the r0 test 3 strobes
    localparam int          STIM_CYCLES     = RESET_CYCLES + 14 + N_SINGLE + N_PAIR + N_CHAIN
                                              + N_BURST + 3;
    localparam int          WATCHDOG_CYCLES = STIM_CYCLES * 4 + 100;

    logic        clk;
    logic        reset_i;
    logic        fetch_ok1;
    logic        fetch_ok2;
    word_t       fetch_word1;
    word_t       fetch_word2;
    logic        fifo_full;
    logic        m_wen;
    reg_addr_t   m_wnum;
    word_t       m_wdata;
    word_t       m_pc;
    logic        s_wen;
    reg_addr_t   s_wnum;
    word_t       s_wdata;
    word_t       s_pc;

    // reference model
    word_t       arch [32];
    word_t       pend_inst [$];
    word_t       pend_pc [$];
    word_t       next_pc;
    reg_addr_t   exp_m_wnum;
    word_t       exp_m_wdata;
    word_t       exp_m_pc;
    reg_addr_t   exp_s_wnum;
    word_t       exp_s_wdata;
    word_t       exp_s_pc;
    int unsigned writes_sent;
    int unsigned writes_retired;
    int unsigned errors;
    int unsigned mark;
    int unsigned passed;
    int unsigned failed;
    bit          saw_full;

    tb_clock #(.PERIOD_NS(CLK_PERIOD)) u_clock (.clk_o(clk));

    dual_issue_core #(
        .FIFO_DEPTH (8),
        .START_PC   (START_PC)
    ) i_dut (
        .clk               (clk),
        .reset_i           (reset_i),
        .inst_data_ok1_i   (fetch_ok1),
        .inst_data_ok2_i   (fetch_ok2),
        .inst_rdata1_i     (fetch_word1),
        .inst_rdata2_i     (fetch_word2),
        .fifo_full_o       (fifo_full),
        .wb_master_wen_o   (m_wen),
        .wb_master_wnum_o  (m_wnum),
        .wb_master_wdata_o (m_wdata),
        .wb_master_pc_o    (m_pc),
        .wb_slave_wen_o    (s_wen),
        .wb_slave_wnum_o   (s_wnum),
        .wb_slave_wdata_o  (s_wdata),
        .wb_slave_pc_o     (s_pc)
    );

    bind dual_issue_core core_chk u_core_chk (
        .clk           (clk),
        .reset_i       (reset_i),
        .ok1_i         (inst_data_ok1_i),
        .full_i        (fifo_full_o),
        .m_wen_i       (wb_master_wen_o),
        .m_wnum_i      (wb_master_wnum_o),
        .m_wdata_i     (wb_master_wdata_o),
        .m_pc_i        (wb_master_pc_o),
        .s_wen_i       (wb_slave_wen_o),
        .s_wnum_i      (wb_slave_wnum_o),
        .s_wdata_i     (wb_slave_wdata_o),
        .s_pc_i        (wb_slave_pc_o),
        .exp_m_wnum_i  (tb_dual_issue.exp_m_wnum),
        .exp_m_wdata_i (tb_dual_issue.exp_m_wdata),
        .exp_m_pc_i    (tb_dual_issue.exp_m_pc),
        .exp_s_wnum_i  (tb_dual_issue.exp_s_wnum),
        .exp_s_wdata_i (tb_dual_issue.exp_s_wdata),
        .exp_s_pc_i    (tb_dual_issue.exp_s_pc)
    );

    // destination of a kept instruction, zero when the word writes nothing
    function automatic reg_addr_t dest_of(word_t w);
        case (w[31:26])
            6'h00: begin
                case (w[5:0])
                    6'h00, 6'h21, 6'h23, 6'h24, 6'h25, 6'h26, 6'h2a: return w[15:11];
                    default: return 5'd0;
                endcase
            end
            6'h09, 6'h0d, 6'h0f: return w[20:16];
            default: return 5'd0;
        endcase
    endfunction

    function automatic word_t model_result(word_t w);
        word_t rs;
        word_t rt;
        rs = arch[w[25:21]];
        rt = arch[w[20:16]];
        case (w[31:26])
            6'h09: return rs + {{16{w[15]}}, w[15:0]};
            6'h0d: return rs | {16'h0000, w[15:0]};
            6'h0f: return {w[15:0], 16'h0000};
            default: begin
                case (w[5:0])
                    6'h21: return rs + rt;
                    6'h23: return rs - rt;
                    6'h24: return rs & rt;
                    6'h25: return rs | rt;
                    6'h26: return rs ^ rt;
                    6'h2a: return ($signed(rs) < $signed(rt)) ? 32'd1 : 32'd0;
                    default: return rt << w[10:6];
                endcase
            end
        endcase
    endfunction

    // kind 0..9 is addu subu and or xor slt sll addiu ori lui
    function automatic word_t make_inst(int kind, reg_addr_t d, reg_addr_t a, reg_addr_t b);
        logic [15:0] imm;
        imm = 16'($urandom);
        case (kind)
            0: return {6'h00, a, b, d, 5'd0, 6'h21};
            1: return {6'h00, a, b, d, 5'd0, 6'h23};
            2: return {6'h00, a, b, d, 5'd0, 6'h24};
            3: return {6'h00, a, b, d, 5'd0, 6'h25};
            4: return {6'h00, a, b, d, 5'd0, 6'h26};
            5: return {6'h00, a, b, d, 5'd0, 6'h2a};
            6: return {6'h00, 5'd0, b, d, imm[4:0], 6'h00};
            7: return {6'h09, a, d, imm};
            8: return {6'h0d, a, d, imm};
            default: return {6'h0f, 5'd0, d, imm};
        endcase
    endfunction

    function automatic reg_addr_t rand_reg(int unsigned lo, int unsigned hi);
        return reg_addr_t'($urandom_range(hi, lo));
    endfunction

    // mostly low registers so that pairs often depend, opcode 3f is outside the subset
    function automatic word_t burst_word();
        if ($urandom_range(7, 0) == 0) begin
            return {6'h3f, 26'($urandom)};
        end
        return make_inst($urandom_range(9, 0), rand_reg(0, 3), rand_reg(0, 3), rand_reg(0, 3));
    endfunction

    task automatic push_word(word_t w);
        pend_inst.push_back(w);
        pend_pc.push_back(next_pc);
        next_pc += 32'd4;
        if (dest_of(w) != 5'd0) begin
            writes_sent++;
        end
    endtask

    task automatic send(word_t w1, word_t w2, bit two);
        @(posedge clk);
        #DRIVE_DELAY;
        while (fifo_full) begin
            saw_full  = 1'b1;
            fetch_ok1 = 1'b0;
            fetch_ok2 = 1'b0;
            @(posedge clk);
            #DRIVE_DELAY;
        end
        fetch_ok1   = 1'b1;
        fetch_ok2   = two;
        fetch_word1 = w1;
        fetch_word2 = w2;
        push_word(w1);
        if (two) begin
            push_word(w2);
        end
    endtask

    // next write in program order, no-op words are skipped
    task automatic retire(output reg_addr_t num, output word_t data, output word_t pc);
        bit    found;
        word_t w;
        word_t p;
        found = 1'b0;
        num   = 'x;
        data  = 'x;
        pc    = 'x;
        while (!found && pend_inst.size() > 0) begin
            w = pend_inst.pop_front();
            p = pend_pc.pop_front();
            if (dest_of(w) != 5'd0) begin
                num       = dest_of(w);
                data      = model_result(w);
                pc        = p;
                arch[num] = data;
                writes_retired++;
                found     = 1'b1;
            end
        end
        if (!found) begin
            errors++;
            $display("t=%0t writeback seen with no write left in program order", $time);
        end
    endtask

    task automatic drain();
        int n;
        @(posedge clk);
        #DRIVE_DELAY;
        fetch_ok1 = 1'b0;
        fetch_ok2 = 1'b0;
        n = 0;
        while (writes_retired != writes_sent && n < DRAIN_LIMIT) begin
            @(posedge clk);
            n++;
        end
        // trailing no-ops still have to leave the queue
        repeat (4) @(posedge clk);
        #DRIVE_DELAY;
        assert (writes_retired == writes_sent) else begin
            errors++;
            $error("writes did not all retire: %0d sent, %0d retired", writes_sent,
                writes_retired);
        end
    endtask

    task automatic end_test(string name);
        int unsigned total;
        drain();
        total = errors + i_dut.u_core_chk.fail_cnt;
        if (total == mark) begin
            passed++;
            $display("test %-12s ok", name);
        end else begin
            failed++;
            $display("test %-12s FAILED, %0d errors", name, total - mark);
        end
        mark = total;
    endtask

    // master lane first, so a slave write to the same register wins
    always @(negedge clk) begin
        if (!reset_i) begin
            if (m_wen) begin
                retire(exp_m_wnum, exp_m_wdata, exp_m_pc);
            end
            if (s_wen) begin
                retire(exp_s_wnum, exp_s_wdata, exp_s_pc);
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        word_t     w1;
        word_t     held;
        reg_addr_t d1;
        reg_addr_t prev;
        reg_addr_t prev2;
        int        kind;
        void'($urandom(SEED));
        reset_i        = 1'b1;
        fetch_ok1      = 1'b0;
        fetch_ok2      = 1'b0;
        fetch_word1    = '0;
        fetch_word2    = '0;
        next_pc        = START_PC;
        writes_sent    = 0;
        writes_retired = 0;
        errors         = 0;
        mark           = 0;
        passed         = 0;
        failed         = 0;
        saw_full       = 1'b0;
        held           = '0;
        foreach (arch[i]) begin
            arch[i] = '0;
        end

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset_i = 1'b0;
        @(posedge clk);
        #DRIVE_DELAY;
        assert (!m_wen && !s_wen && !fifo_full) else begin
            errors++;
            $error("a writeback enable or fifo_full_o is high right after reset");
        end
        end_test("reset");

        // lui then ori gives r1..r7 known values
        for (int r = 1; r < 8; r++) begin
            send(make_inst(9, reg_addr_t'(r), 5'd0, 5'd0), '0, 1'b0);
            send(make_inst(8, reg_addr_t'(r), reg_addr_t'(r), 5'd0), '0, 1'b0);
        end
        for (int i = 0; i < N_SINGLE; i++) begin
            send(make_inst(i % 10, rand_reg(1, 7), rand_reg(1, 7), rand_reg(1, 7)), '0, 1'b0);
        end
        end_test("single_ops");

        for (int i = 0; i < N_PAIR; i++) begin
            w1   = make_inst($urandom_range(9, 0), rand_reg(8, 15), rand_reg(1, 7), rand_reg(1, 7));
            held = make_inst($urandom_range(9, 0), rand_reg(16, 23), rand_reg(1, 7),
                rand_reg(1, 7));
            send(w1, held, 1'b1);
        end
        end_test("pairs");

        // rs reads the previous result, rt the one before it
        prev  = 5'd1;
        prev2 = 5'd2;
        for (int i = 0; i < N_CHAIN; i++) begin
            kind  = $urandom_range(8, 0);
            d1    = rand_reg(1, 7);
            w1    = make_inst(kind, d1, prev, (kind == 6) ? prev : prev2);
            prev2 = prev;
            prev  = d1;
            if (i % 2 == 0) begin
                held = w1;
            end else begin
                send(held, w1, 1'b1);
            end
        end
        end_test("chains");

        saw_full = 1'b0;
        for (int i = 0; i < N_BURST; i++) begin
            w1   = burst_word();
            held = burst_word();
            send(w1, held, 1'b1);
        end
        assert (saw_full) else begin
            errors++;
            $error("fifo_full_o never went high during the double-strobe burst");
        end
        end_test("backpressure");

        send(make_inst(7, 5'd0, 5'd1, 5'd0), '0, 1'b0);
        send(make_inst(9, 5'd0, 5'd0, 5'd0), '0, 1'b0);
        send(make_inst(0, 5'd5, 5'd0, 5'd1), make_inst(3, 5'd6, 5'd0, 5'd0), 1'b1);
        end_test("r0");

        $display("%0d tests run, %0d passed, %0d failed", passed + failed, passed, failed);
        if (failed == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
